// ==== verilog/cam_cfg_pkg.sv ====
`default_nettype none

package cam_cfg_pkg;

  // Widths of the fields held in each store entry.
  localparam int TAG_WIDTH  = 8;   // width of the lookup tag.
  localparam int DATA_WIDTH = 16;  // width of the stored payload.

  // Width of the hit, miss and illegal counters.
  localparam int CNT_WIDTH  = 16;  // counters wrap at this width.

endpackage : cam_cfg_pkg

`default_nettype wire

// ==== verilog/cam_cmd_pkg.sv ====
`default_nettype none

package cam_cmd_pkg;

  import cam_cfg_pkg::*;

  typedef enum logic [1:0] {
    NOP   = 2'd0,
    WRITE = 2'd1,
    READ  = 2'd2,
    FREE  = 2'd3
  } cam_op_e;

  // Write view of a command word.
  typedef struct packed {
    cam_op_e                 op;
    logic [TAG_WIDTH-1:0]    tag;
    logic [DATA_WIDTH-1:0]   data;
  } cam_wr_cmd_t;

  // Tag-only view, used by READ and FREE.
  typedef struct packed {
    cam_op_e                 op;
    logic [TAG_WIDTH-1:0]    tag;
    logic [DATA_WIDTH-1:0]   rsvd;  // must be zero for a legal command.
  } cam_tag_cmd_t;

  typedef union packed {
    cam_wr_cmd_t  wr;
    cam_tag_cmd_t tag;
  } cam_cmd_u;

  typedef struct packed {
    logic                    wr;    // write strobe.
    logic                    rd;    // read strobe.
    logic                    fr;    // free strobe.
    logic [TAG_WIDTH-1:0]    tag;
    logic [DATA_WIDTH-1:0]   data;
  } cam_req_t;

  typedef struct packed {
    logic                    valid;
    logic                    hit;
    logic [TAG_WIDTH-1:0]    tag;
    logic [DATA_WIDTH-1:0]   data;  // zero on a miss.
  } cam_resp_t;

endpackage : cam_cmd_pkg

`default_nettype wire

// ==== verilog/cam_cmd_decoder.sv ====
`default_nettype none

module cam_cmd_decoder
  import cam_cfg_pkg::*, cam_cmd_pkg::*;
(
  input  wire            clk,
  input  wire            reset_n,

  input  wire            cmd_valid_i,
  input  wire cam_cmd_u  cmd_i,

  output cam_req_t       req_o,
  output logic           illegal_o
);

  cam_req_t req_d;
  logic     illegal_d;

  // The opcode sits in the same bits in both views of the word.
  always_comb begin
    req_d     = '0;
    illegal_d = 1'b0;
    if (cmd_valid_i) begin
      case (cmd_i.wr.op)
        WRITE: begin
          req_d.wr   = 1'b1;
          req_d.tag  = cmd_i.wr.tag;
          req_d.data = cmd_i.wr.data;
        end
        READ, FREE: begin
          if (cmd_i.tag.rsvd != {DATA_WIDTH{1'b0}}) begin
            illegal_d = 1'b1;  // reserved bits set, so the command is dropped.
          end else begin
            req_d.rd  = (cmd_i.tag.op == READ);
            req_d.fr  = (cmd_i.tag.op == FREE);
            req_d.tag = cmd_i.tag.tag;
          end
        end
        default: begin
          // NOP is legal and produces nothing.
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      req_o     <= '0;
      illegal_o <= 1'b0;
    end else begin
      req_o     <= req_d;      // strobes last exactly one cycle.
      illegal_o <= illegal_d;
    end
  end

endmodule : cam_cmd_decoder

`default_nettype wire

// ==== verilog/cam_tag_store.sv ====
`default_nettype none

module cam_tag_store
  import cam_cfg_pkg::*, cam_cmd_pkg::*;
#(
  parameter int NUM_ENTRIES = 16
) (
  input  wire            clk,
  input  wire            reset_n,

  input  wire cam_req_t  req_i,

  output cam_resp_t      rsp_o
);

  localparam int IDX_W = $clog2(NUM_ENTRIES);

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [TAG_WIDTH-1:0]  stored_tag;
    logic                  free;
  } entry_t;

  entry_t [NUM_ENTRIES-1:0]            entries;

  logic   [NUM_ENTRIES-1:0][IDX_W-1:0] victim_chain;  // running highest free index.
  logic   [IDX_W-1:0]                  victim_idx;
  logic   [NUM_ENTRIES-1:0]            match;
  logic                                hit_any;
  logic   [IDX_W-1:0]                  hit_idx;
  logic   [DATA_WIDTH-1:0]             hit_data;
  logic                                rd_hit;

  // Walk upward so that a higher free entry replaces a lower one.
  // Entry 0 is the fallback when nothing is free.
  always_comb begin
    victim_chain[0] = '0;
    for (int i = 1; i < NUM_ENTRIES; i++) begin
      victim_chain[i] = entries[i].free ? IDX_W'(i) : victim_chain[i-1];
    end
  end

  assign victim_idx = victim_chain[NUM_ENTRIES-1];

  always_comb begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      match[i] = !entries[i].free && (entries[i].stored_tag == req_i.tag);
    end
  end

  // Scanning downward leaves the lowest matching index in hit_idx.
  always_comb begin
    hit_any = 1'b0;
    hit_idx = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (match[i]) begin
        hit_any = 1'b1;
        hit_idx = IDX_W'(i);
      end
    end
  end

  assign hit_data = entries[hit_idx].data;
  assign rd_hit   = req_i.rd && hit_any;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        entries[i].data       <= '0;
        entries[i].stored_tag <= '0;
        entries[i].free       <= 1'b1;  // every entry starts out free.
      end
    end else begin
      if (req_i.wr) begin
        entries[victim_idx].data       <= req_i.data;
        entries[victim_idx].stored_tag <= req_i.tag;
        entries[victim_idx].free       <= 1'b0;
      end
      if ((req_i.rd || req_i.fr) && hit_any) begin
        entries[hit_idx].free <= 1'b1;  // a hit consumes only the entry it read.
      end
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rsp_o <= '0;
    end else begin
      rsp_o.valid <= req_i.rd;                     // one response per read, none for free.
      rsp_o.hit   <= rd_hit;
      rsp_o.tag   <= req_i.tag;
      rsp_o.data  <= rd_hit ? hit_data : '0;
    end
  end

endmodule : cam_tag_store

`default_nettype wire

// ==== verilog/cam_resp_collector.sv ====
`default_nettype none

module cam_resp_collector
  import cam_cfg_pkg::*, cam_cmd_pkg::*;
(
  input  wire                   clk,
  input  wire                   reset_n,

  input  wire cam_resp_t        rsp_i,
  input  wire                   illegal_i,

  output cam_resp_t             resp_o,
  output logic [CNT_WIDTH-1:0]  hit_count_o,
  output logic [CNT_WIDTH-1:0]  miss_count_o,
  output logic [CNT_WIDTH-1:0]  illegal_count_o
);

  logic count_hit;
  logic count_miss;

  assign count_hit  = rsp_i.valid &&  rsp_i.hit;
  assign count_miss = rsp_i.valid && !rsp_i.hit;

  // Read result goes out one cycle after the store produces it.
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      resp_o <= '0;
    end else begin
      resp_o <= rsp_i;
    end
  end

  // Counters move on the same edge as resp_o and simply wrap.
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      hit_count_o     <= '0;
      miss_count_o    <= '0;
      illegal_count_o <= '0;
    end else begin
      if (count_hit) begin
        hit_count_o <= hit_count_o + CNT_WIDTH'(1);
      end
      if (count_miss) begin
        miss_count_o <= miss_count_o + CNT_WIDTH'(1);
      end
      if (illegal_i) begin
        illegal_count_o <= illegal_count_o + CNT_WIDTH'(1);  // two cycles after the command.
      end
    end
  end

endmodule : cam_resp_collector

`default_nettype wire

// ==== verilog/cam_top.sv ====
`default_nettype none

module cam_top
  import cam_cfg_pkg::*, cam_cmd_pkg::*;
#(
  parameter int NUM_ENTRIES = 16  // power of two, at least 2.
) (
  input  wire                   clk,
  input  wire                   reset_n,

  input  wire                   cmd_valid_i,
  input  wire cam_cmd_u         cmd_i,

  output cam_resp_t             resp_o,
  output logic [CNT_WIDTH-1:0]  hit_count_o,
  output logic [CNT_WIDTH-1:0]  miss_count_o,
  output logic [CNT_WIDTH-1:0]  illegal_count_o
);

  wire cam_req_t  req;
  wire            illegal;
  wire cam_resp_t rsp;

  cam_cmd_decoder u_decoder (
    .clk         (clk),
    .reset_n     (reset_n),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .req_o       (req),
    .illegal_o   (illegal)
  );

  cam_tag_store #(
    .NUM_ENTRIES (NUM_ENTRIES)
  ) u_store (
    .clk     (clk),
    .reset_n (reset_n),
    .req_i   (req),
    .rsp_o   (rsp)
  );

  cam_resp_collector u_collector (
    .clk             (clk),
    .reset_n         (reset_n),
    .rsp_i           (rsp),
    .illegal_i       (illegal),
    .resp_o          (resp_o),
    .hit_count_o     (hit_count_o),
    .miss_count_o    (miss_count_o),
    .illegal_count_o (illegal_count_o)
  );

endmodule : cam_top

`default_nettype wire

// ==== bench/cam_checker.sv ====
`default_nettype none

module cam_checker
  import cam_cfg_pkg::*, cam_cmd_pkg::*;
#(
  parameter int NUM_ENTRIES = 4
) (
  input  wire                  clk,
  input  wire                  reset_n,
  input  wire                  cmd_valid_i,
  input  wire cam_cmd_u        cmd_i,
  input  wire                  exp_hit_i,        // hit expected by the stimulus table.
  input  wire cam_resp_t       resp_i,
  input  wire [CNT_WIDTH-1:0]  hit_count_i,
  input  wire [CNT_WIDTH-1:0]  miss_count_i,
  input  wire [CNT_WIDTH-1:0]  illegal_count_i,
  input  wire                  check_counts_i,
  output logic                 done_o,
  output int                   mismatch_count_o,
  output int                   other_count_o
);

  logic [DATA_WIDTH-1:0] m_data [NUM_ENTRIES];
  logic [TAG_WIDTH-1:0]  m_tag  [NUM_ENTRIES];
  logic                  m_free [NUM_ENTRIES];
  cam_resp_t             exp_q  [$];         // one slot per cycle, three deep.
  int                    n_hit;
  int                    n_miss;
  int                    n_illegal;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      mismatch_count_o++;
      $display("mismatch %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // Applies one sampled command to the model and returns the response it should cause.
  task automatic apply_command(output cam_resp_t exp);
    int idx;
    idx = -1;
    exp = '0;
    if (cmd_valid_i) begin
      case (cmd_i.wr.op)
        WRITE: begin
          idx = 0;
          for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (m_free[i]) idx = i;  // highest free entry wins.
          end
          m_data[idx] = cmd_i.wr.data;
          m_tag[idx]  = cmd_i.wr.tag;
          m_free[idx] = 1'b0;
        end
        READ, FREE: begin
          if (cmd_i.tag.rsvd != '0) begin
            n_illegal++;
          end else begin
            for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
              if (!m_free[i] && m_tag[i] == cmd_i.tag.tag) idx = i;
            end
            if (idx >= 0) m_free[idx] = 1'b1;
            if (cmd_i.tag.op == READ) begin
              exp.valid = 1'b1;
              exp.hit   = (idx >= 0);
              exp.tag   = cmd_i.tag.tag;
              exp.data  = (idx >= 0) ? m_data[idx] : '0;
              if (exp.hit) n_hit++;
              else n_miss++;
              if (exp.hit != exp_hit_i) begin
                other_count_o++;
                $display("table expects hit %0d for tag %h but the model gives %0d",
                         exp_hit_i, exp.tag, exp.hit);
              end
            end
          end
        end
        default: begin
        end
      endcase
    end
  endtask

  task automatic compare_response(input cam_resp_t exp);
    if (exp.valid != resp_i.valid) begin
      other_count_o++;
      if (exp.valid) $display("read response for tag %h did not arrive on time", exp.tag);
      else $display("response for tag %h arrived without a read", resp_i.tag);
    end else if (exp.valid) begin
      check_value("resp_o.hit", 32'(exp.hit), 32'(resp_i.hit));
      check_value("resp_o.tag", 32'(exp.tag), 32'(resp_i.tag));
      check_value("resp_o.data", 32'(exp.data), 32'(resp_i.data));
    end
  endtask

  always @(posedge clk or negedge reset_n) begin : watch
    cam_resp_t expected;
    cam_resp_t next;
    if (!reset_n) begin
      exp_q.delete();
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        m_data[i] = '0;
        m_tag[i]  = '0;
        m_free[i] = 1'b1;
      end
      n_hit            = 0;
      n_miss           = 0;
      n_illegal        = 0;
      done_o           = 1'b0;
      mismatch_count_o = 0;
      other_count_o    = 0;
    end else begin
      expected = '0;
      if (exp_q.size() >= 3) expected = exp_q.pop_front();
      compare_response(expected);
      apply_command(next);
      exp_q.push_back(next);
      if (check_counts_i && !done_o) begin
        check_value("hit_count_o", 32'(n_hit), 32'(hit_count_i));
        check_value("miss_count_o", 32'(n_miss), 32'(miss_count_i));
        check_value("illegal_count_o", 32'(n_illegal), 32'(illegal_count_i));
        done_o = 1'b1;
      end
    end
  end

endmodule : cam_checker

`default_nettype wire

// ==== bench/cam_tb.sv ====
`default_nettype none

module cam_tb
  import cam_cfg_pkg::*, cam_cmd_pkg::*;
();

  localparam int TB_ENTRIES   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int DRAIN_CYCLES = 6;   // lets the last read and counters settle.
  localparam int SLACK_CYCLES = 20;

  typedef struct packed {
    logic     valid;
    logic     exp_hit;  // only meaningful on a read row.
    cam_cmd_u cmd;
  } row_t;

  logic                 clk;
  logic                 reset_n;
  logic                 cmd_valid_i;
  cam_cmd_u             cmd_i;
  logic                 exp_hit;
  logic                 check_counts;
  cam_resp_t            resp_o;
  logic [CNT_WIDTH-1:0] hit_count_o;
  logic [CNT_WIDTH-1:0] miss_count_o;
  logic [CNT_WIDTH-1:0] illegal_count_o;
  logic                 check_done;
  int                   mismatches;
  int                   other_errors;

  row_t rows [64];
  int   n_rows = 0;
  int   seed = 35;
  int   cycle_count = 0;

  cam_top #(
    .NUM_ENTRIES (TB_ENTRIES)
  ) dut_i (
    .clk             (clk),
    .reset_n         (reset_n),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_i           (cmd_i),
    .resp_o          (resp_o),
    .hit_count_o     (hit_count_o),
    .miss_count_o    (miss_count_o),
    .illegal_count_o (illegal_count_o)
  );

  cam_checker #(
    .NUM_ENTRIES (TB_ENTRIES)
  ) u_checker (
    .clk              (clk),
    .reset_n          (reset_n),
    .cmd_valid_i      (cmd_valid_i),
    .cmd_i            (cmd_i),
    .exp_hit_i        (exp_hit),
    .resp_i           (resp_o),
    .hit_count_i      (hit_count_o),
    .miss_count_i     (miss_count_o),
    .illegal_count_i  (illegal_count_o),
    .check_counts_i   (check_counts),
    .done_o           (check_done),
    .mismatch_count_o (mismatches),
    .other_count_o    (other_errors)
  );

  always #5 clk = ~clk;

  function automatic logic [DATA_WIDTH-1:0] random_data();
    return DATA_WIDTH'($random(seed));
  endfunction

  // the last field is data for a write and the reserved bits otherwise.
  task automatic add_row(input logic valid, input cam_op_e op, input logic [TAG_WIDTH-1:0] tag,
                         input logic [DATA_WIDTH-1:0] field, input logic hit);
    rows[n_rows].valid       = valid;
    rows[n_rows].exp_hit     = hit;
    rows[n_rows].cmd.wr.op   = op;
    rows[n_rows].cmd.wr.tag  = tag;
    rows[n_rows].cmd.wr.data = field;
    n_rows++;
  endtask

  task automatic build_table();
    add_row(1'b0, NOP,   8'h00, 16'h0000, 1'b0);
    add_row(1'b1, READ,  8'h11, 16'h0000, 1'b0);  // empty store misses.
    add_row(1'b1, NOP,   8'h00, 16'h0000, 1'b0);
    add_row(1'b0, NOP,   8'h00, 16'h0000, 1'b0);
    add_row(1'b1, WRITE, 8'h11, random_data(), 1'b0);  // fills entry 3.
    add_row(1'b1, WRITE, 8'h22, random_data(), 1'b0);
    add_row(1'b1, WRITE, 8'h33, random_data(), 1'b0);
    add_row(1'b1, WRITE, 8'h44, random_data(), 1'b0);  // fills entry 0.
    add_row(1'b1, READ,  8'h11, 16'h0000, 1'b1);
    add_row(1'b1, READ,  8'h22, 16'h0000, 1'b1);
    add_row(1'b1, READ,  8'h11, 16'h0000, 1'b0);  // already consumed.
    add_row(1'b1, WRITE, 8'h55, random_data(), 1'b0);
    add_row(1'b1, WRITE, 8'h66, random_data(), 1'b0);
    add_row(1'b1, READ,  8'h33, 16'h0000, 1'b1);
    add_row(1'b1, WRITE, 8'h33, random_data(), 1'b0);
    add_row(1'b1, WRITE, 8'h77, random_data(), 1'b0);  // store full, so entry 0 goes.
    add_row(1'b1, READ,  8'h44, 16'h0000, 1'b0);
    add_row(1'b1, READ,  8'h77, 16'h0000, 1'b1);
    add_row(1'b1, FREE,  8'h55, 16'h0000, 1'b0);
    add_row(1'b1, READ,  8'h55, 16'h0000, 1'b0);
    add_row(1'b1, READ,  8'h66, 16'h0100, 1'b0);  // reserved bits set.
    add_row(1'b1, FREE,  8'h66, 16'h8001, 1'b0);
    add_row(1'b1, NOP,   8'h66, 16'h0000, 1'b0);
    add_row(1'b1, READ,  8'h66, 16'h0000, 1'b1);
    add_row(1'b0, NOP,   8'h00, 16'h0000, 1'b0);
    add_row(1'b1, WRITE, 8'h11, random_data(), 1'b0);
    add_row(1'b1, READ,  8'h11, 16'h0000, 1'b1);  // right behind its write.
    add_row(1'b1, READ,  8'h33, 16'h0000, 1'b1);
    add_row(1'b1, WRITE, 8'h22, random_data(), 1'b0);
    add_row(1'b1, READ,  8'h22, 16'h0000, 1'b1);
    add_row(1'b1, READ,  8'h11, 16'h0000, 1'b0);
    add_row(1'b0, NOP,   8'h00, 16'h0000, 1'b0);
    add_row(1'b1, WRITE, 8'h44, random_data(), 1'b0);
    add_row(1'b1, WRITE, 8'h55, random_data(), 1'b0);
    add_row(1'b1, READ,  8'h55, 16'h0000, 1'b1);
    add_row(1'b1, READ,  8'h44, 16'h0000, 1'b1);
    add_row(1'b1, READ,  8'h99, 16'h0000, 1'b0);
    add_row(1'b1, FREE,  8'h99, 16'h0000, 1'b0);  // no match, nothing happens.
    add_row(1'b0, NOP,   8'h00, 16'h0000, 1'b0);
    add_row(1'b1, READ,  8'h33, 16'h0000, 1'b0);
  endtask

  initial begin
    clk          = 1'b0;
    reset_n      = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_i        = '0;
    exp_hit      = 1'b0;
    check_counts = 1'b0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset_n <= 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      @(negedge clk);
      cmd_valid_i <= rows[r].valid;
      cmd_i       <= rows[r].cmd;
      exp_hit     <= rows[r].exp_hit;
    end
    @(negedge clk);
    cmd_valid_i <= 1'b0;
    cmd_i       <= '0;
    repeat (DRAIN_CYCLES) @(negedge clk);
    check_counts <= 1'b1;
    wait (check_done);
    $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (n_rows > 0 && cycle_count >= n_rows + RESET_CYCLES + SLACK_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_count);
      $display("FAIL: see errors above");
      $finish;
    end
  end

endmodule : cam_tb

`default_nettype wire

// ==== sources.f ====
verilog/cam_cfg_pkg.sv
verilog/cam_cmd_pkg.sv
verilog/cam_cmd_decoder.sv
verilog/cam_tag_store.sv
verilog/cam_resp_collector.sv
verilog/cam_top.sv
bench/cam_checker.sv
bench/cam_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing -f sources.f --top-module cam_tb -Mdir obj_dir -o cam_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/cam_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi
